/* source/spike_pkg.sv */
package spike_pkg;

    ////////////////////////////////////////
    // host bus widths
    ////////////////////////////////////////
    // word address, eight slots
    localparam int wb_addr_width = 3;
    localparam int wb_data_width = 32;

    ////////////////////////////////////////
    // register map
    ////////////////////////////////////////
    // bit 0 enable, bit 1 restart (write only)
    localparam logic [wb_addr_width-1:0] addr_ctrl = 3'd0;
    // window length in ticks, 16 bits
    localparam logic [wb_addr_width-1:0] addr_window = 3'd1;
    // waveform half word, low half first
    localparam logic [wb_addr_width-1:0] addr_feed = 3'd2;
    localparam logic [wb_addr_width-1:0] addr_count_live = 3'd3;
    localparam logic [wb_addr_width-1:0] addr_count_last = 3'd4;
    localparam logic [wb_addr_width-1:0] addr_windows = 3'd5;
    // bit 0 spike flag, bits 12..8 loaded elements
    localparam logic [wb_addr_width-1:0] addr_status = 3'd6;

    ////////////////////////////////////////
    // waveform memory and tick rate
    ////////////////////////////////////////
    localparam int wave_depth = 16;
    localparam int wave_ptr_width = 4;
    // clock cycles per simulation tick
    localparam int sim_div = 4;

    // one waveform element
    // fed as two half words, played back as one word
    typedef union packed {
        logic [31:0] word;
        logic [1:0][15:0] half;
    } spike_element_t;

endpackage

/* source/spike_regs.sv */
`timescale 1ns/1ns

module spike_regs (
    input  logic                                 ep50trig,
    input  logic                                 reset_global,
    // wishbone classic slave
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [spike_pkg::wb_addr_width-1:0]  wb_adr,
    input  logic [spike_pkg::wb_data_width-1:0]  wb_dat_w,
    output logic [spike_pkg::wb_data_width-1:0]  wb_dat_r,
    output logic                                 wb_ack,
    // control to the datapath
    output logic                                 enable,
    output logic                                 restart,
    output logic [15:0]                          window_len,
    output logic                                 feed_write,
    output logic [15:0]                          feed_data,
    // status from the datapath
    input  logic [31:0]                          count_live,
    input  logic [31:0]                          count_last,
    input  logic [31:0]                          windows_done,
    input  logic                                 spike_in_window,
    input  logic [spike_pkg::wave_ptr_width:0]   loaded_count
);

    import spike_pkg::*;

    logic                     wb_req;
    logic [wb_data_width-1:0] read_word;

    // new request, ack not yet given
    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    ////////////////////////////////////////
    // writes and strobes
    ////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            wb_ack <= 1'b0;
            enable <= 1'b0;
            restart <= 1'b0;
            feed_write <= 1'b0;
            window_len <= 16'd1;
        end
        else
        begin
            // ack one cycle after the request
            wb_ack <= wb_req;
            // restart pulses during the ack cycle
            restart <= wb_req && wb_we && (wb_adr == addr_ctrl) && wb_dat_w[1];
            // feeding only while stopped, otherwise dropped
            feed_write <= wb_req && wb_we && (wb_adr == addr_feed) && !enable;
            if (wb_req && wb_we)
            begin
                case (wb_adr)
                    addr_ctrl:
                    begin
                        enable <= wb_dat_w[0];
                    end
                    addr_window:
                    begin
                        window_len <= wb_dat_w[15:0];
                    end
                    default:
                    begin
                        // read-only or unmapped, nothing stored
                    end
                endcase
            end
        end
    end

    // half word for the player
    always_ff @(posedge ep50trig)
    begin
        if (wb_req && wb_we)
        begin
            feed_data <= wb_dat_w[15:0];
        end
    end

    ////////////////////////////////////////
    // read path
    ////////////////////////////////////////
    always_comb
    begin
        read_word = '0;
        case (wb_adr)
            addr_ctrl:
            begin
                // restart reads back as 0
                read_word[0] = enable;
            end
            addr_window:
            begin
                read_word[15:0] = window_len;
            end
            addr_count_live:
            begin
                read_word = count_live;
            end
            addr_count_last:
            begin
                read_word = count_last;
            end
            addr_windows:
            begin
                read_word = windows_done;
            end
            addr_status:
            begin
                read_word[0] = spike_in_window;
                read_word[8 +: wave_ptr_width + 1] = loaded_count;
            end
            default:
            begin
                // feed and unmapped read as zero
                read_word = '0;
            end
        endcase
    end

    // data valid with ack
    always_ff @(posedge ep50trig)
    begin
        if (wb_req)
        begin
            wb_dat_r <= read_word;
        end
    end

endmodule

/* source/tick_divider.sv */
`timescale 1ns/1ns

module tick_divider (
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        enable,
    input  logic        restart,
    input  logic [15:0] window_len,
    output logic        sim_tick,
    output logic        window_end
);

    import spike_pkg::*;

    logic [$clog2(sim_div)-1:0] phase;
    logic [15:0]                tick_cnt;
    logic [15:0]                win_last;

    // length 0 behaves like length 1
    assign win_last = (window_len == 16'd0) ? 16'd0 : window_len - 16'd1;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            phase <= '0;
            tick_cnt <= 16'd0;
            sim_tick <= 1'b0;
            window_end <= 1'b0;
        end
        else
        begin
            // strobes are single cycle
            sim_tick <= 1'b0;
            window_end <= 1'b0;
            if (restart)
            begin
                phase <= '0;
                tick_cnt <= 16'd0;
            end
            else if (enable)
            begin
                if (phase == sim_div - 1)
                begin
                    phase <= '0;
                    sim_tick <= 1'b1;
                    // window boundary rides on the tick
                    if (tick_cnt >= win_last)
                    begin
                        tick_cnt <= 16'd0;
                        window_end <= 1'b1;
                    end
                    else
                    begin
                        tick_cnt <= tick_cnt + 16'd1;
                    end
                end
                else
                begin
                    phase <= phase + 1'b1;
                end
            end
            // disabled, phase and tick count hold
        end
    end

endmodule

/* source/waveform_player.sv */
`timescale 1ns/1ns

module waveform_player (
    input  logic                                ep50trig,
    input  logic                                reset_global,
    input  logic                                restart,
    input  logic                                feed_write,
    input  logic [15:0]                         feed_data,
    input  logic                                sim_tick,
    output logic                                spike,
    output logic [spike_pkg::wave_ptr_width:0]  loaded_count
);

    import spike_pkg::*;

    spike_element_t            wave_mem [wave_depth];
    spike_element_t            pending_elem;
    spike_element_t            commit_elem;
    logic                      half_sel;
    logic                      wave_full;
    logic                      commit;
    logic [wave_ptr_width-1:0] play_ptr;
    logic [wave_ptr_width:0]   next_play;

    ////////////////////////////////////////
    // feeding
    ////////////////////////////////////////
    assign wave_full = (loaded_count >= wave_depth);
    // second half completes an element
    assign commit = feed_write && half_sel && !wave_full;

    // low half from the holding register, high half from the bus
    always_comb
    begin
        commit_elem = pending_elem;
        commit_elem.half[1] = feed_data;
    end

    always_ff @(posedge ep50trig)
    begin
        if (feed_write && !half_sel)
        begin
            pending_elem.half[0] <= feed_data;
        end
        // write pointer is the loaded count
        if (commit)
        begin
            wave_mem[loaded_count[wave_ptr_width-1:0]] <= commit_elem;
        end
    end

    ////////////////////////////////////////
    // playback
    ////////////////////////////////////////
    assign next_play = {1'b0, play_ptr} + 1'b1;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            half_sel <= 1'b0;
            loaded_count <= '0;
            play_ptr <= '0;
            spike <= 1'b0;
        end
        else if (restart)
        begin
            // waveform itself survives a restart
            half_sel <= 1'b0;
            play_ptr <= '0;
            spike <= 1'b0;
        end
        else
        begin
            if (feed_write)
            begin
                half_sel <= !half_sel;
            end
            if (commit)
            begin
                loaded_count <= loaded_count + 1'b1;
            end
            if (sim_tick)
            begin
                if (loaded_count == '0)
                begin
                    // nothing loaded, stay quiet
                    spike <= 1'b0;
                end
                else
                begin
                    // any non-zero element is a spike
                    spike <= (wave_mem[play_ptr].word != 32'd0);
                    // loop at the end of the loaded part
                    if (next_play >= loaded_count)
                        play_ptr <= '0;
                    else
                        play_ptr <= next_play[wave_ptr_width-1:0];
                end
            end
        end
    end

endmodule

/* source/spike_counter.sv */
`timescale 1ns/1ns

module spike_counter (
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        restart,
    input  logic        sim_tick,
    input  logic        window_end,
    input  logic        spike,
    output logic [31:0] count_live,
    output logic [31:0] count_last,
    output logic [31:0] windows_done,
    output logic        spike_in_window
);

    // any spike so far in the running window
    logic window_hit;

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || restart)
        begin
            count_live <= 32'd0;
            count_last <= 32'd0;
            windows_done <= 32'd0;
            spike_in_window <= 1'b0;
            window_hit <= 1'b0;
        end
        else if (sim_tick)
        begin
            // spike here is the element of the previous tick
            if (window_end)
            begin
                // close the window, include this sample
                count_last <= count_live + {31'd0, spike};
                count_live <= 32'd0;
                windows_done <= windows_done + 32'd1;
                // flag keeps the closed window until the next spike
                spike_in_window <= window_hit || spike;
                window_hit <= 1'b0;
            end
            else
            begin
                count_live <= count_live + {31'd0, spike};
                if (spike)
                begin
                    window_hit <= 1'b1;
                    spike_in_window <= 1'b1;
                end
            end
        end
    end

endmodule

/* source/spike_counter_top.sv */
`timescale 1ns/1ns

module spike_counter_top (
    input  logic                                 ep50trig,
    input  logic                                 reset_global,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [spike_pkg::wb_addr_width-1:0]  wb_adr,
    input  logic [spike_pkg::wb_data_width-1:0]  wb_dat_w,
    output logic [spike_pkg::wb_data_width-1:0]  wb_dat_r,
    output logic                                 wb_ack,
    output logic                                 spike,
    output logic                                 window_end
);

    import spike_pkg::*;

    // control from the register block
    logic                    enable;
    logic                    restart;
    logic [15:0]             window_len;
    logic                    feed_write;
    logic [15:0]             feed_data;
    // datapath
    logic                    sim_tick;
    logic [wave_ptr_width:0] loaded_count;
    logic [31:0]             count_live;
    logic [31:0]             count_last;
    logic [31:0]             windows_done;
    logic                    spike_in_window;

    ////////////////////////////////////////
    // host registers
    ////////////////////////////////////////
    spike_regs u_regs (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_w        (wb_dat_w),
        .wb_dat_r        (wb_dat_r),
        .wb_ack          (wb_ack),
        .enable          (enable),
        .restart         (restart),
        .window_len      (window_len),
        .feed_write      (feed_write),
        .feed_data       (feed_data),
        .count_live      (count_live),
        .count_last      (count_last),
        .windows_done    (windows_done),
        .spike_in_window (spike_in_window),
        .loaded_count    (loaded_count)
    );

    ////////////////////////////////////////
    // tick, waveform and counting
    ////////////////////////////////////////
    // tick strobes stand in for derived clocks
    tick_divider u_ticks (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .enable       (enable),
        .restart      (restart),
        .window_len   (window_len),
        .sim_tick     (sim_tick),
        .window_end   (window_end)
    );

    waveform_player u_player (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .restart      (restart),
        .feed_write   (feed_write),
        .feed_data    (feed_data),
        .sim_tick     (sim_tick),
        .spike        (spike),
        .loaded_count (loaded_count)
    );

    spike_counter u_counter (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .restart         (restart),
        .sim_tick        (sim_tick),
        .window_end      (window_end),
        .spike           (spike),
        .count_live      (count_live),
        .count_last      (count_last),
        .windows_done    (windows_done),
        .spike_in_window (spike_in_window)
    );

endmodule

/* bench/wb_host_tasks.svh */
`ifndef WB_HOST_TASKS_SVH
`define WB_HOST_TASKS_SVH

// longest wait for ack, in cycles
localparam int ack_limit = 8;

////////////////////////////////////////
// failure and checks
////////////////////////////////////////
task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    checks_done++;
    if (act_val !== exp_val)
    begin
        $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp_val, act_val);
        fail_run();
    end
endtask

////////////////////////////////////////
// wishbone classic master
////////////////////////////////////////
// one request, held until ack, driven on the falling edge
task automatic wb_transfer(input logic write, input logic [wb_addr_width-1:0] addr,
                           input logic [31:0] data, output logic [31:0] rdata);
    int waited;
    @(negedge ep50trig);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = write;
    wb_adr = addr;
    wb_dat_w = data;
    waited = 0;
    @(negedge ep50trig);
    while (!wb_ack && waited < ack_limit)
    begin
        @(negedge ep50trig);
        waited++;
    end
    if (!wb_ack)
    begin
        $display("access to address %0d got no ack", addr);
        fail_run();
    end
    else
    begin
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    end
endtask

// random pause between accesses
task automatic idle_gap();
    int unsigned n;
    n = $urandom % 4;
    repeat (n) @(negedge ep50trig);
endtask

task automatic write_reg(input logic [wb_addr_width-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    wb_transfer(1'b1, addr, data, unused);
    idle_gap();
endtask

task automatic read_reg(input logic [wb_addr_width-1:0] addr, output logic [31:0] data);
    wb_transfer(1'b0, addr, 32'd0, data);
endtask

// low half first, then high half
task automatic feed_element(input logic [31:0] elem);
    write_reg(addr_feed, {16'd0, elem[15:0]});
    write_reg(addr_feed, {16'd0, elem[31:16]});
endtask

`endif

/* bench/spike_counter_tb.sv */
`timescale 1ns/1ns

module spike_counter_tb;

    import spike_pkg::*;

    localparam string golden_path = "bench/spike_golden.txt";
    // elements loaded before the enabled-feed probe
    localparam int first_batch = 12;
    localparam int max_elems = 32;
    localparam int max_windows = 16;

    logic                     ep50trig;
    logic                     reset_global;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [wb_data_width-1:0] wb_dat_w;
    logic [wb_data_width-1:0] wb_dat_r;
    logic                     wb_ack;
    logic                     spike;
    logic                     window_end;

    // golden contents
    int          elem_count;
    logic [31:0] elems [max_elems];
    int          window_len_g;
    int          run_windows_g;
    int          expected [max_windows];

    // what the monitor saw on the exported strobes
    int          win_ends = 0;
    int          spike_cycles = 0;
    int          spike_per_window [max_windows];

    int          checks_done = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] value;

    `include "wb_host_tasks.svh"

    spike_counter_top u_dut (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .spike        (spike),
        .window_end   (window_end)
    );

    // 40 ns period
    always #20 ep50trig = ~ep50trig;

    // run guard with its limit set once the golden file is known
    always @(posedge ep50trig)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d clock cycles, the tests did not finish", cycle_count);
            fail_run();
        end
    end

    ////////////////////////////////////////
    // spike and window_end monitor
    ////////////////////////////////////////
    // each sample holds spike for sim_div cycles
    always @(posedge ep50trig)
    begin
        if (spike === 1'b1)
            spike_cycles = spike_cycles + 1;
        if (window_end === 1'b1)
        begin
            if (win_ends < max_windows)
                spike_per_window[win_ends] = spike_cycles;
            win_ends = win_ends + 1;
            spike_cycles = 0;
        end
    end

    ////////////////////////////////////////
    // golden file
    ////////////////////////////////////////
    task automatic load_golden();
        int    fd;
        int    parsed;
        int    n;
        string header;
        fd = $fopen(golden_path, "r");
        if (fd == 0)
        begin
            $display("cannot open the golden file %s", golden_path);
            fail_run();
        end
        else
        begin
            // two lines of column notes on top
            void'($fgets(header, fd));
            void'($fgets(header, fd));
            parsed = $fscanf(fd, "%d", elem_count);
            n = (elem_count > max_elems) ? max_elems : elem_count;
            for (int i = 0; i < n; i++)
                parsed += $fscanf(fd, "%h", elems[i]);
            parsed += $fscanf(fd, "%d", window_len_g);
            parsed += $fscanf(fd, "%d", run_windows_g);
            n = (run_windows_g > max_windows) ? max_windows : run_windows_g;
            for (int i = 0; i < n; i++)
                parsed += $fscanf(fd, "%d", expected[i]);
            $fclose(fd);
            if (parsed != 3 + elem_count + run_windows_g || elem_count <= first_batch)
            begin
                $display("golden file %s is incomplete or malformed", golden_path);
                fail_run();
            end
        end
    endtask

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////
    task automatic test_registers();
        logic [31:0] rd;
        // upper bits of the window register do not exist
        write_reg(addr_window, 32'habcd_1234);
        read_reg(addr_window, rd);
        check_value("window readback", 32'h0000_1234, rd);
        write_reg(addr_ctrl, 32'h1);
        read_reg(addr_ctrl, rd);
        check_value("enable set", 32'h1, rd);
        write_reg(addr_ctrl, 32'h0);
        read_reg(addr_ctrl, rd);
        check_value("enable clear", 32'h0, rd);
        write_reg(3'd7, 32'hffff_ffff);
        read_reg(3'd7, rd);
        check_value("unmapped read", 32'h0, rd);
    endtask

    task automatic test_feeding();
        logic [31:0] rd;
        int          capped;
        for (int i = 0; i < first_batch; i++)
            feed_element(elems[i]);
        read_reg(addr_status, rd);
        check_value("loaded first batch", first_batch, {27'd0, rd[12:8]});
        // feeding while running is dropped
        write_reg(addr_ctrl, 32'h1);
        feed_element(elems[first_batch]);
        read_reg(addr_status, rd);
        check_value("loaded while enabled", first_batch, {27'd0, rd[12:8]});
        write_reg(addr_ctrl, 32'h0);
        for (int i = first_batch; i < elem_count; i++)
            feed_element(elems[i]);
        capped = (elem_count > wave_depth) ? wave_depth : elem_count;
        read_reg(addr_status, rd);
        check_value("loaded capped", capped, {27'd0, rd[12:8]});
    endtask

    // poll the tally, then flag and last count of each window
    task automatic run_windows(input string run_name);
        logic [31:0] prev;
        logic [31:0] now;
        logic [31:0] rd;
        prev = 32'd0;
        for (int w = 0; w < run_windows_g; w++)
        begin
            now = prev;
            while (now == prev)
                read_reg(addr_windows, now);
            // flag read right away before the next sampled spike
            read_reg(addr_status, rd);
            check_value($sformatf("%s window %0d flag", run_name, w + 1),
                        {31'd0, expected[w] != 0}, {31'd0, rd[0]});
            read_reg(addr_count_last, rd);
            check_value($sformatf("%s window %0d count", run_name, w + 1), expected[w], rd);
            check_value($sformatf("%s window %0d tally", run_name, w + 1), prev + 1, now);
            check_value($sformatf("%s window %0d window_end pulses", run_name, w + 1),
                        w + 1, win_ends);
            check_value($sformatf("%s window %0d spike cycles", run_name, w + 1),
                        expected[w] * sim_div, spike_per_window[w]);
            prev = now;
            idle_gap();
        end
    endtask

    initial
    begin
        ep50trig = 1'b0;
        reset_global = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        void'($urandom(32'h07df_adc3));
        load_golden();
        // two runs with start-up and bus overhead plus feeding
        cycle_limit = 2 * ((run_windows_g * window_len_g + 4) * sim_div + 200)
                      + 10 * (elem_count + 1);
        repeat (2) @(negedge ep50trig);
        reset_global = 1'b0;

        test_registers();
        test_feeding();

        // first run from a clean phase
        write_reg(addr_window, window_len_g);
        write_reg(addr_ctrl, 32'h2);
        win_ends = 0;
        spike_cycles = 0;
        write_reg(addr_ctrl, 32'h1);
        run_windows("run 1");

        // stop and restart with everything back to zero
        write_reg(addr_ctrl, 32'h0);
        write_reg(addr_ctrl, 32'h2);
        read_reg(addr_count_live, value);
        check_value("restart count_live", 32'd0, value);
        read_reg(addr_count_last, value);
        check_value("restart count_last", 32'd0, value);
        read_reg(addr_windows, value);
        check_value("restart windows_done", 32'd0, value);
        win_ends = 0;
        spike_cycles = 0;
        write_reg(addr_ctrl, 32'h1);
        run_windows("run 2");

        if (checks_done == 0)
        begin
            $display("no checks were run");
            fail_run();
        end
        else
        begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* bench/spike_golden.txt */
// element count (dec), then one waveform element per line (hex), beyond 16 dropped
// then window length in ticks, windows to run, expected count_last per window (dec)
18
00000001
00000000
00010000
00000000
00000000
deadbeef
00000000
80000000
00008000
00000000
00000000
00000000
00000000
00000000
12340000
00000000
ffffffff
00000001
5
6
2
3
0
3
2
1

/* verilog.f */
+incdir+bench
source/spike_pkg.sv
source/spike_regs.sv
source/tick_divider.sv
source/waveform_player.sv
source/spike_counter.sv
source/spike_counter_top.sv
bench/spike_counter_tb.sv

/* Makefile */
# Verilator build and run of the spike counter testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = spike_counter_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_TEXT = Result: PASSED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run and check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
